// ==== project.f ====
+incdir+.
layer_norm_pkg.sv
lane_fifo.sv
row_mean.sv
row_variance.sv
inv_sqrt.sv
row_scale.sv
layer_norm.sv
layer_norm_assert.sv
layer_norm_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the layer-norm testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module layer_norm_tb -f project.f \
  -o layer_norm_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/layer_norm_sim +verilator+error+limit+1000)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'NO ERRORS'; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1

// ==== layer_norm_tb.sv ====
`timescale 1ns/1ps
`include "layer_norm_defines.svh"

module layer_norm_tb;

  localparam int CLK_PERIOD = 8;
  localparam int RAND_ROWS  = 16;
  localparam int EDGE_ROWS  = 6;
  localparam int TOTAL_ROWS = 1 + 3 * RAND_ROWS + EDGE_ROWS;
  // Worst case per row with stalls and gaps, plus reset and drain margin
  localparam int ROW_BUDGET = 200;
  localparam int TIMEOUT_NS = (TOTAL_ROWS * ROW_BUDGET + 1000) * CLK_PERIOD;
  localparam int ROW_W      = `LN_ROW_LEN * `LN_DATA_W;
  localparam int BEAT_W     = `LN_LANES * `LN_DATA_W;

  logic                         clk = 1'b0;
  logic                         arst_n;
  layer_norm_pkg::sample_beat_t in_data;
  logic                         in_valid;
  logic                         in_ready;
  layer_norm_pkg::sample_beat_t out_data;
  logic                         out_valid;
  logic                         out_ready;

  logic [15:0]       lfsr = 16'd53610;
  logic [BEAT_W-1:0] exp_q [$];
  logic              gap_on = 1'b0;
  logic              stall_on = 1'b0;
  int                errors = 0;
  int                checks = 0;
  int                rows_sent = 0;
  int                beats_seen = 0;

  layer_norm layer_norm_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Expected normalized row with sample k in bits [8k+7:8k]
  function automatic logic [ROW_W-1:0] norm_row(input logic [ROW_W-1:0] row);
    int               smp [`LN_ROW_LEN];
    int               diff [`LN_ROW_LEN];
    int               sum;
    int               mean;
    int               sq_sum;
    int               var_v;
    int               root;
    int               cand;
    int               q;
    longint           prod;
    logic [ROW_W-1:0] res;
    sum    = 0;
    sq_sum = 0;
    for (int k = 0; k < `LN_ROW_LEN; k++) begin
      smp[k] = int'($signed(row[8*k +: 8]));
      sum    = sum + smp[k];
    end
    mean = sum >>> `LN_LOG_ROW;
    for (int k = 0; k < `LN_ROW_LEN; k++) begin
      diff[k] = smp[k] - mean;
      sq_sum  = sq_sum + diff[k] * diff[k];
    end
    var_v = (sq_sum / `LN_ROW_LEN) % (1 << `LN_VAR_W);
    // Largest root with root*root*var no more than one
    root = 0;
    for (int b = `LN_ISQRT_W - 1; b >= 0; b--) begin
      cand = root | (1 << b);
      prod = longint'(cand) * cand * var_v;
      if (prod <= 65536) begin
        root = cand;
      end
    end
    for (int k = 0; k < `LN_ROW_LEN; k++) begin
      q = (diff[k] * root) >>> `LN_FRAC_W;
      if (q > 127) begin
        q = 127;
      end else if (q < -128) begin
        q = -128;
      end
      res[8*k +: 8] = q[7:0];
    end
    return res;
  endfunction

  // Galois LFSR stepped once per bit handed out
  function automatic logic [15:0] lfsr_bits(input int n);
    logic [15:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      val  = {val[14:0], lfsr[0]};
    end
    return val;
  endfunction

  task automatic check_value(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Error at time %0t: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic send_row(input logic [ROW_W-1:0] row);
    logic [ROW_W-1:0] exp_row;
    for (int b = 0; b < `LN_BEATS; b++) begin
      if (gap_on) begin
        while (lfsr_bits(1) == 16'd0) begin
          in_valid <= 1'b0;
          @(posedge clk);
        end
      end
      in_valid <= 1'b1;
      in_data  <= row[BEAT_W*b +: BEAT_W];
      @(posedge clk);
      while (!in_ready) begin
        @(posedge clk);
      end
    end
    // Row is complete, so its output beats may now appear
    exp_row = norm_row(row);
    for (int b = 0; b < `LN_BEATS; b++) begin
      exp_q.push_back(exp_row[BEAT_W*b +: BEAT_W]);
    end
    rows_sent++;
  endtask

  // Even rows span the full range and odd rows stay small for large roots
  task automatic send_random_rows(input int count);
    logic [ROW_W-1:0] row;
    logic [15:0]      r;
    for (int n = 0; n < count; n++) begin
      for (int k = 0; k < `LN_ROW_LEN; k++) begin
        if (n % 2 == 0) begin
          r = lfsr_bits(8);
          row[8*k +: 8] = r[7:0];
        end else begin
          r = lfsr_bits(4);
          row[8*k +: 8] = {{4{r[3]}}, r[3:0]};
        end
      end
      send_row(row);
    end
  endtask

  task automatic wait_drain();
    in_valid <= 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  // Sink side stalls at random only while enabled
  initial begin : stall_drive
    logic pick;
    out_ready = 1'b1;
    forever begin
      @(negedge clk);
      pick = stall_on ? (lfsr_bits(1) != 16'd0) : 1'b1;
      @(posedge clk);
      out_ready <= pick;
    end
  end

  always @(posedge clk) begin : compare_out
    logic [BEAT_W-1:0] exp_beat;
    if (arst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected output beat at time %0t with no complete row pending", $time);
      end else begin
        exp_beat = exp_q.pop_front();
        for (int l = 0; l < `LN_LANES; l++) begin
          check_value(int'(out_data[l]), int'($signed(exp_beat[8*l +: 8])),
                      $sformatf("row %0d lane %0d", beats_seen / `LN_BEATS, l));
        end
      end
      // Every output transfer counts, expected or not
      beats_seen++;
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Run timed out after %0d ns with %0d output beats still missing",
             TIMEOUT_NS, exp_q.size());
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : main_seq
    int total;
    arst_n   = 1'b0;
    in_valid = 1'b0;
    in_data  = '0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    check_value(int'(out_valid), 0, "out_valid after reset");
    check_value(int'(in_ready), 1, "in_ready after reset");

    // Constant row with zero variance
    send_row(64'h1515151515151515);
    wait_drain();

    send_random_rows(RAND_ROWS);
    wait_drain();

    stall_on = 1'b1;
    send_random_rows(RAND_ROWS);
    wait_drain();
    stall_on = 1'b0;

    gap_on = 1'b1;
    send_random_rows(RAND_ROWS);
    wait_drain();

    // Extreme rows with both gaps and stalls
    stall_on = 1'b1;
    send_row(64'h7F807F807F807F80);
    send_row(64'h00007F0000000000);
    send_row(64'h0000000000800000);
    send_row(64'h8080808080808080);
    send_row(64'h0000000300000000);
    send_row(64'h0000000000000100);
    wait_drain();
    stall_on = 1'b0;
    gap_on   = 1'b0;

    // Idle window to expose any extra output beat
    repeat (50) @(posedge clk);
    check_value(beats_seen, rows_sent * `LN_BEATS, "output beat count");

    total = errors + layer_norm_i.layer_norm_assert_i.fail_count;
    $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
             checks, errors, layer_norm_i.layer_norm_assert_i.fail_count);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== layer_norm_assert.sv ====
`timescale 1ns/1ps

module layer_norm_assert (
  input logic                         clk,
  input logic                         arst_n,
  input logic                         in_ready,
  input layer_norm_pkg::sample_beat_t out_data,
  input logic                         out_valid,
  input logic                         out_ready
);

  int fail_count = 0;

  // Output beat holds while the sink stalls
  property out_hold_p;
    @(posedge clk) disable iff (!arst_n)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_data));
  endproperty

  property reset_idle_p;
    @(posedge clk) $rose(arst_n) |-> !out_valid;
  endproperty

  property reset_ready_p;
    @(posedge clk) $rose(arst_n) |-> in_ready;
  endproperty

  out_hold_a: assert property (out_hold_p)
    else begin
      fail_count++;
      $error("out_valid or out_data changed while out_ready was low");
    end

  reset_idle_a: assert property (reset_idle_p)
    else begin
      fail_count++;
      $error("out_valid high in the cycle after reset release");
    end

  reset_ready_a: assert property (reset_ready_p)
    else begin
      fail_count++;
      $error("in_ready low in the cycle after reset release");
    end

endmodule

bind layer_norm layer_norm_assert layer_norm_assert_i (
  .clk       (clk),
  .arst_n    (arst_n),
  .in_ready  (in_ready),
  .out_data  (out_data),
  .out_valid (out_valid),
  .out_ready (out_ready)
);

// ==== layer_norm.sv ====
`timescale 1ns/1ps

module layer_norm (
  input  logic                         clk,
  input  logic                         arst_n,
  input  layer_norm_pkg::sample_beat_t in_data,
  input  logic                         in_valid,
  output logic                         in_ready,
  output layer_norm_pkg::sample_beat_t out_data,
  output logic                         out_valid,
  input  logic                         out_ready
);

  localparam int SAMPLE_BEAT_W = $bits(layer_norm_pkg::sample_beat_t);
  localparam int DIFF_BEAT_W   = $bits(layer_norm_pkg::diff_beat_t);

  logic                         mean_in_valid;
  logic                         mean_in_ready;
  logic                         fifo_in_valid;
  logic                         fifo_in_ready;
  layer_norm_pkg::sample_t      mean;
  logic                         mean_valid;
  logic                         mean_ready;
  layer_norm_pkg::sample_beat_t sample_data;
  logic                         sample_valid;
  logic                         sample_ready;
  layer_norm_pkg::diff_beat_t   diff_in_data;
  logic                         diff_in_valid;
  logic                         diff_in_ready;
  layer_norm_pkg::diff_beat_t   diff_out_data;
  logic                         diff_out_valid;
  logic                         diff_out_ready;
  layer_norm_pkg::var_t         variance;
  logic                         variance_valid;
  logic                         variance_ready;
  layer_norm_pkg::isqrt_t       isqrt;
  logic                         isqrt_valid;
  logic                         isqrt_ready;

  // Input beat goes to the mean stage and the sample FIFO together
  assign in_ready      = mean_in_ready && fifo_in_ready;
  assign mean_in_valid = in_valid && fifo_in_ready;
  assign fifo_in_valid = in_valid && mean_in_ready;

  row_mean row_mean_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_data    (in_data),
    .in_valid   (mean_in_valid),
    .in_ready   (mean_in_ready),
    .mean       (mean),
    .mean_valid (mean_valid),
    .mean_ready (mean_ready)
  );

  // Raw samples kept for the replay pass
  lane_fifo #(
    .WIDTH (SAMPLE_BEAT_W)
  ) sample_fifo_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (in_data),
    .in_valid  (fifo_in_valid),
    .in_ready  (fifo_in_ready),
    .out_data  (sample_data),
    .out_valid (sample_valid),
    .out_ready (sample_ready)
  );

  row_variance row_variance_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .mean           (mean),
    .mean_valid     (mean_valid),
    .mean_ready     (mean_ready),
    .sample_data    (sample_data),
    .sample_valid   (sample_valid),
    .sample_ready   (sample_ready),
    .diff_data      (diff_in_data),
    .diff_valid     (diff_in_valid),
    .diff_ready     (diff_in_ready),
    .variance       (variance),
    .variance_valid (variance_valid),
    .variance_ready (variance_ready)
  );

  // Differences wait here while the inverse root is searched
  lane_fifo #(
    .WIDTH (DIFF_BEAT_W)
  ) diff_fifo_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (diff_in_data),
    .in_valid  (diff_in_valid),
    .in_ready  (diff_in_ready),
    .out_data  (diff_out_data),
    .out_valid (diff_out_valid),
    .out_ready (diff_out_ready)
  );

  inv_sqrt inv_sqrt_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .variance       (variance),
    .variance_valid (variance_valid),
    .variance_ready (variance_ready),
    .isqrt          (isqrt),
    .isqrt_valid    (isqrt_valid),
    .isqrt_ready    (isqrt_ready)
  );

  row_scale row_scale_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .isqrt       (isqrt),
    .isqrt_valid (isqrt_valid),
    .isqrt_ready (isqrt_ready),
    .diff_data   (diff_out_data),
    .diff_valid  (diff_out_valid),
    .diff_ready  (diff_out_ready),
    .out_data    (out_data),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

endmodule

// ==== row_scale.sv ====
`timescale 1ns/1ps
`include "layer_norm_defines.svh"

module row_scale (
  input  logic                         clk,
  input  logic                         arst_n,
  input  layer_norm_pkg::isqrt_t       isqrt,
  input  logic                         isqrt_valid,
  output logic                         isqrt_ready,
  input  layer_norm_pkg::diff_beat_t   diff_data,
  input  logic                         diff_valid,
  output logic                         diff_ready,
  output layer_norm_pkg::sample_beat_t out_data,
  output logic                         out_valid,
  input  logic                         out_ready
);

  localparam int PROD_W  = `LN_DIFF_W + `LN_ISQRT_W + 1;
  localparam int SHIFT_W = PROD_W - `LN_FRAC_W;
  localparam int CNT_W   = $clog2(`LN_BEATS);
  localparam logic signed [SHIFT_W-1:0] MAX_OUT = 2 ** (`LN_DATA_W - 1) - 1;
  localparam logic signed [SHIFT_W-1:0] MIN_OUT = -(2 ** (`LN_DATA_W - 1));

  logic signed [PROD_W-1:0]     prod [`LN_LANES];
  logic signed [SHIFT_W-1:0]    scaled [`LN_LANES];
  layer_norm_pkg::sample_beat_t sat;
  logic [CNT_W-1:0]             beat_cnt;
  logic                         out_advance;
  logic                         diff_take;
  logic                         last_beat;

  // Output register is free when empty or being drained
  assign out_advance = !out_valid || out_ready;
  assign diff_ready  = isqrt_valid && out_advance;
  assign diff_take   = diff_valid && diff_ready;
  assign last_beat   = (beat_cnt == CNT_W'(`LN_BEATS - 1));
  // Root stays with this row until its last beat
  assign isqrt_ready = diff_take && last_beat;

  always_comb begin
    for (int i = 0; i < `LN_LANES; i++) begin
      prod[i]   = $signed(diff_data[i]) * $signed({1'b0, isqrt});
      // Arithmetic shift floors toward minus infinity
      scaled[i] = SHIFT_W'(prod[i] >>> `LN_FRAC_W);
      if (scaled[i] > MAX_OUT) begin
        sat[i] = MAX_OUT[`LN_DATA_W-1:0];
      end else if (scaled[i] < MIN_OUT) begin
        sat[i] = MIN_OUT[`LN_DATA_W-1:0];
      end else begin
        sat[i] = scaled[i][`LN_DATA_W-1:0];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      beat_cnt  <= '0;
    end else begin
      if (diff_take) begin
        out_valid <= 1'b1;
        beat_cnt  <= last_beat ? '0 : beat_cnt + 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (diff_take) begin
      out_data <= sat;
    end
  end

endmodule

// ==== inv_sqrt.sv ====
`timescale 1ns/1ps
`include "layer_norm_defines.svh"

module inv_sqrt (
  input  logic                   clk,
  input  logic                   arst_n,
  input  layer_norm_pkg::var_t   variance,
  input  logic                   variance_valid,
  output logic                   variance_ready,
  output layer_norm_pkg::isqrt_t isqrt,
  output logic                   isqrt_valid,
  input  logic                   isqrt_ready
);

  localparam int PROD_W = 2 * `LN_ISQRT_W + `LN_VAR_W;
  localparam int BIT_W  = $clog2(`LN_ISQRT_W);
  // One in the y*y*V format, 16 fraction bits
  localparam logic [PROD_W-1:0] LIMIT = PROD_W'(1) << (4 * `LN_FRAC_W);

  layer_norm_pkg::isqrt_state_e state;
  layer_norm_pkg::var_t         var_q;
  layer_norm_pkg::isqrt_t       root;
  layer_norm_pkg::isqrt_t       cand;
  logic [BIT_W-1:0]             bit_idx;
  logic [PROD_W-1:0]            prod;

  assign variance_ready = (state == layer_norm_pkg::IDLE);
  assign isqrt_valid    = (state == layer_norm_pkg::DONE);
  assign isqrt          = root;

  // Trial root with the current bit set
  assign cand = root | (layer_norm_pkg::isqrt_t'(1) << bit_idx);
  assign prod = PROD_W'(cand) * PROD_W'(cand) * PROD_W'(var_q);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= layer_norm_pkg::IDLE;
      bit_idx <= '0;
    end else begin
      case (state)
        layer_norm_pkg::IDLE: begin
          if (variance_valid) begin
            state   <= layer_norm_pkg::SEARCH;
            bit_idx <= BIT_W'(`LN_ISQRT_W - 1);
          end
        end
        layer_norm_pkg::SEARCH: begin
          // MSB first, one bit per cycle
          if (bit_idx == '0) begin
            state <= layer_norm_pkg::DONE;
          end else begin
            bit_idx <= bit_idx - 1'b1;
          end
        end
        layer_norm_pkg::DONE: begin
          if (isqrt_ready) begin
            state <= layer_norm_pkg::IDLE;
          end
        end
        default: begin
          state <= layer_norm_pkg::IDLE;
        end
      endcase
    end
  end

  // Zero variance keeps every bit, giving 255
  always_ff @(posedge clk) begin
    if (variance_valid && variance_ready) begin
      var_q <= variance;
      root  <= '0;
    end else if (state == layer_norm_pkg::SEARCH && prod <= LIMIT) begin
      root <= cand;
    end
  end

endmodule

// ==== row_variance.sv ====
`timescale 1ns/1ps
`include "layer_norm_defines.svh"

module row_variance (
  input  logic                         clk,
  input  logic                         arst_n,
  input  layer_norm_pkg::sample_t      mean,
  input  logic                         mean_valid,
  output logic                         mean_ready,
  input  layer_norm_pkg::sample_beat_t sample_data,
  input  logic                         sample_valid,
  output logic                         sample_ready,
  output layer_norm_pkg::diff_beat_t   diff_data,
  output logic                         diff_valid,
  input  logic                         diff_ready,
  output layer_norm_pkg::var_t         variance,
  output logic                         variance_valid,
  input  logic                         variance_ready
);

  localparam int SQ_W  = 2 * `LN_DIFF_W;
  localparam int ACC_W = `LN_VAR_W + `LN_LOG_ROW;
  localparam int CNT_W = $clog2(`LN_BEATS);

  layer_norm_pkg::stage_state_e state;
  logic signed [SQ_W-1:0]       sq [`LN_LANES];
  logic [ACC_W-1:0]             acc;
  logic [ACC_W-1:0]             acc_next;
  logic [ACC_W-1:0]             acc_shift;
  logic [CNT_W-1:0]             beat_cnt;
  logic                         take;
  logic                         last_beat;

  // Differences go straight to the FIFO, so a sample waits for its space
  assign diff_valid   = (state == layer_norm_pkg::COLLECT) && mean_valid && sample_valid;
  assign sample_ready = (state == layer_norm_pkg::COLLECT) && mean_valid && diff_ready;
  assign take         = sample_valid && sample_ready;
  assign last_beat    = (beat_cnt == CNT_W'(`LN_BEATS - 1));

  assign variance_valid = (state == layer_norm_pkg::HOLD);
  // Mean is released together with the variance
  assign mean_ready     = variance_valid && variance_ready;

  always_comb begin
    acc_next = acc;
    for (int i = 0; i < `LN_LANES; i++) begin
      diff_data[i] = {sample_data[i][`LN_DATA_W-1], sample_data[i]} -
                     {mean[`LN_DATA_W-1], mean};
      sq[i]        = $signed(diff_data[i]) * $signed(diff_data[i]);
      // Square never exceeds 255*255, so 16 bits hold it exactly
      acc_next     = acc_next + {{(ACC_W - `LN_VAR_W){1'b0}}, sq[i][`LN_VAR_W-1:0]};
    end
  end

  // Floor mean of the squares
  assign acc_shift = acc_next >> `LN_LOG_ROW;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= layer_norm_pkg::COLLECT;
      acc      <= '0;
      beat_cnt <= '0;
    end else begin
      case (state)
        layer_norm_pkg::COLLECT: begin
          if (take) begin
            if (last_beat) begin
              acc      <= '0;
              beat_cnt <= '0;
              state    <= layer_norm_pkg::HOLD;
            end else begin
              acc      <= acc_next;
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        layer_norm_pkg::HOLD: begin
          if (variance_ready) begin
            state <= layer_norm_pkg::COLLECT;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take && last_beat) begin
      variance <= acc_shift[`LN_VAR_W-1:0];
    end
  end

endmodule

// ==== row_mean.sv ====
`timescale 1ns/1ps
`include "layer_norm_defines.svh"

module row_mean (
  input  logic                         clk,
  input  logic                         arst_n,
  input  layer_norm_pkg::sample_beat_t in_data,
  input  logic                         in_valid,
  output logic                         in_ready,
  output layer_norm_pkg::sample_t      mean,
  output logic                         mean_valid,
  input  logic                         mean_ready
);

  localparam int ACC_W = `LN_DATA_W + $clog2(`LN_ROW_LEN);
  localparam int CNT_W = $clog2(`LN_BEATS);

  layer_norm_pkg::stage_state_e state;
  logic signed [ACC_W-1:0]      acc;
  logic signed [ACC_W-1:0]      acc_next;
  logic signed [ACC_W-1:0]      sum_shift;
  logic [CNT_W-1:0]             beat_cnt;
  logic                         take;
  logic                         last_beat;

  assign in_ready   = (state == layer_norm_pkg::COLLECT);
  assign mean_valid = (state == layer_norm_pkg::HOLD);
  assign take       = in_valid && in_ready;
  assign last_beat  = (beat_cnt == CNT_W'(`LN_BEATS - 1));

  // Running sum plus both lanes of the current beat
  always_comb begin
    acc_next = acc;
    for (int i = 0; i < `LN_LANES; i++) begin
      acc_next = acc_next + {{(ACC_W - `LN_DATA_W){in_data[i][`LN_DATA_W-1]}}, in_data[i]};
    end
  end

  // Floor division by the row length
  assign sum_shift = acc_next >>> `LN_LOG_ROW;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= layer_norm_pkg::COLLECT;
      acc      <= '0;
      beat_cnt <= '0;
    end else begin
      case (state)
        layer_norm_pkg::COLLECT: begin
          if (take) begin
            if (last_beat) begin
              acc      <= '0;
              beat_cnt <= '0;
              state    <= layer_norm_pkg::HOLD;
            end else begin
              acc      <= acc_next;
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        layer_norm_pkg::HOLD: begin
          if (mean_ready) begin
            state <= layer_norm_pkg::COLLECT;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take && last_beat) begin
      mean <= sum_shift[`LN_DATA_W-1:0];
    end
  end

endmodule

// ==== lane_fifo.sv ====
`timescale 1ns/1ps
`include "layer_norm_defines.svh"

module lane_fifo #(
  parameter int WIDTH = 16
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  localparam int DEPTH = `LN_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Beat storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== layer_norm_pkg.sv ====
`include "layer_norm_defines.svh"

package layer_norm_pkg;

  typedef logic signed [`LN_DATA_W-1:0] sample_t;
  typedef logic signed [`LN_DIFF_W-1:0] diff_t;

  // Lane 0 in the low bits
  typedef sample_t [`LN_LANES-1:0] sample_beat_t;
  typedef diff_t [`LN_LANES-1:0] diff_beat_t;

  typedef logic [`LN_VAR_W-1:0] var_t;
  typedef logic [`LN_ISQRT_W-1:0] isqrt_t;

  typedef enum logic [1:0] {
    IDLE,
    SEARCH,
    DONE
  } isqrt_state_e;

  typedef enum logic {
    COLLECT,
    HOLD
  } stage_state_e;

endpackage

// ==== layer_norm_defines.svh ====
`ifndef LAYER_NORM_DEFINES_SVH
`define LAYER_NORM_DEFINES_SVH

// Row geometry
`define LN_LANES      2
`define LN_ROW_LEN    8
`define LN_BEATS      4
`define LN_LOG_ROW    3

// Samples and outputs, 4 fraction bits
`define LN_DATA_W     8
`define LN_FRAC_W     4
`define LN_DIFF_W     9

// Variance carries 8 fraction bits
`define LN_VAR_W      16

// Inverse root carries 4 fraction bits
`define LN_ISQRT_W    8

// Room for two rows of beats
`define LN_FIFO_DEPTH 8

`endif
